// ==== design/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

////////////////////
// datapath widths
////////////////////

`define RV_XLEN     32 // data and address width
`define RV_ILEN     32 // instruction word width

////////////////////
// register file
////////////////////

`define RV_NUM_REGS 32 // x0 .. x31, x0 hardwired
`define RV_REG_AW   5  // log2 of RV_NUM_REGS

////////////////////
// fetch
////////////////////

`define RV_RESET_PC 32'h0000_0000 // first fetch address after reset

`endif

// ==== design/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // reg-reg alu
        OPC_OP_IMM = 7'b0010011, // reg-imm alu and shifts
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011, // beq .. bgeu
        OPC_JAL    = 7'b1101111,
        OPC_STORE  = 7'b0100011  // sw only
    } opcode_e;

    // alu operations
    // arithmetic/logic ops drive the result, compare ops drive only the flag
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_EQ   = 4'd10, // beq
        ALU_NE   = 4'd11, // bne
        ALU_LT   = 4'd12, // blt, signed
        ALU_GE   = 4'd13, // bge, signed
        ALU_LTU  = 4'd14, // bltu
        ALU_GEU  = 4'd15  // bgeu
    } alu_op_e;

    // first alu operand source
    typedef enum logic [1:0] {
        OP_A_RS1  = 2'd0,
        OP_A_PC   = 2'd1, // jal link
        OP_A_ZERO = 2'd2  // lui
    } op_a_sel_e;

    // second alu operand source
    typedef enum logic [1:0] {
        OP_B_RS2  = 2'd0,
        OP_B_IMM  = 2'd1,
        OP_B_FOUR = 2'd2  // pc + 4 for jal
    } op_b_sel_e;

endpackage

`default_nettype wire

// ==== design/rv_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module rv_decoder
    import rv_pkg::*;
(
    input  logic [`RV_ILEN-1:0]   instr_i,
    output logic [`RV_REG_AW-1:0] rs1_addr_o,
    output logic [`RV_REG_AW-1:0] rs2_addr_o,
    output logic [`RV_REG_AW-1:0] rd_addr_o,
    output logic                  rd_we_o,    // gated with illegal
    output alu_op_e               alu_op_o,
    output op_a_sel_e             op_a_sel_o,
    output op_b_sel_e             op_b_sel_o,
    output logic [`RV_XLEN-1:0]   imm_o,      // sign-extended, type-selected
    output logic                  branch_o,
    output logic                  jal_o,
    output logic                  store_o,    // gated with illegal
    output logic                  illegal_o
);

    opcode_e             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i_type;
    logic [`RV_XLEN-1:0] imm_s_type;
    logic [`RV_XLEN-1:0] imm_b_type;
    logic [`RV_XLEN-1:0] imm_u_type;
    logic [`RV_XLEN-1:0] imm_j_type;
    logic                rd_we;
    logic                store;
    logic                branch;
    logic                illegal;

    // funct3 to alu op, alt is instr[30] for sub / sra
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // fixed instruction fields
    assign opcode     = opcode_e'(instr_i[6:0]);
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rd_addr_o  = instr_i[11:7];

    ////////////////////
    // immediates, sign bit is always instr[31]
    ////////////////////
    assign imm_i_type = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s_type = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    ////////////////////
    // main decode
    ////////////////////
    always_comb begin
        rd_we      = 1'b0; // defaults behave as a nop
        store      = 1'b0;
        branch     = 1'b0;
        jal_o      = 1'b0;
        illegal    = 1'b0;
        alu_op_o   = ALU_ADD;
        op_a_sel_o = OP_A_RS1;
        op_b_sel_o = OP_B_RS2;
        imm_o      = imm_i_type;
        case (opcode)
            OPC_OP: begin
                rd_we    = 1'b1;
                alu_op_o = arith_op(funct3, funct7[5]);
                // 0100000 only valid for sub and sra
                if (funct7 == 7'b0100000) begin
                    illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else if (funct7 != 7'b0000000) begin
                    illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                rd_we      = 1'b1;
                op_b_sel_o = OP_B_IMM;
                // instr[30] only selects sra on the shift-right slot
                alu_op_o   = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'b0000000); // slli
                end else if (funct3 == 3'b101) begin
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            OPC_LUI: begin
                rd_we      = 1'b1;
                op_a_sel_o = OP_A_ZERO; // 0 + imm
                op_b_sel_o = OP_B_IMM;
                imm_o      = imm_u_type;
            end
            OPC_BRANCH: begin
                branch = 1'b1;
                imm_o  = imm_b_type; // target offset, alu only compares
                case (funct3)
                    3'b000:  alu_op_o = ALU_EQ;
                    3'b001:  alu_op_o = ALU_NE;
                    3'b100:  alu_op_o = ALU_LT;
                    3'b101:  alu_op_o = ALU_GE;
                    3'b110:  alu_op_o = ALU_LTU;
                    3'b111:  alu_op_o = ALU_GEU;
                    default: illegal  = 1'b1; // 010, 011
                endcase
            end
            OPC_JAL: begin
                rd_we      = 1'b1;
                jal_o      = 1'b1;
                op_a_sel_o = OP_A_PC;   // link = pc + 4
                op_b_sel_o = OP_B_FOUR;
                imm_o      = imm_j_type;
            end
            OPC_STORE: begin
                store      = 1'b1;
                op_b_sel_o = OP_B_IMM;  // address = rs1 + imm
                imm_o      = imm_s_type;
                illegal    = (funct3 != 3'b010); // word only
            end
            default: begin
                illegal = 1'b1; // loads, jalr, system, fence, auipc ...
            end
        endcase
    end

    // illegal words retire as pc + 4 with no side effect
    assign rd_we_o   = rd_we && !illegal;
    assign store_o   = store && !illegal;
    assign branch_o  = branch && !illegal;
    assign illegal_o = illegal;

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic [`RV_REG_AW-1:0] ra1_i,
    input  logic [`RV_REG_AW-1:0] ra2_i,
    input  logic [`RV_REG_AW-1:0] wa_i,
    input  logic [`RV_XLEN-1:0]   wd_i,
    input  logic                  we_i,
    output logic [`RV_XLEN-1:0]   rd1_o,
    output logic [`RV_XLEN-1:0]   rd2_o
);

    // x1 .. x31, x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

    // asynchronous reads
    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

    // write lands on the retiring edge
    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin // x0 writes dropped
            regs[wa_i] <= wd_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic [`RV_XLEN-1:0] rs1_data_i,
    input  logic [`RV_XLEN-1:0] rs2_data_i,
    input  logic [`RV_XLEN-1:0] imm_i,
    input  alu_op_e             alu_op_i,
    input  op_a_sel_e           op_a_sel_i,
    input  op_b_sel_e           op_b_sel_i,
    input  logic                branch_i,
    input  logic                jal_i,
    input  logic                store_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output logic [`RV_XLEN-1:0] wb_data_o,
    output logic                mem_we_o,
    output logic [`RV_XLEN-1:0] mem_addr_o,
    output logic [`RV_XLEN-1:0] mem_data_o
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic                alu_flag;
    logic                lt_s;     // shared by slt and blt/bge
    logic                lt_u;     // shared by sltu and bltu/bgeu
    logic [4:0]          shamt;
    logic                take_target;

    ////////////////////
    // operand select
    ////////////////////
    always_comb begin
        case (op_a_sel_i)
            OP_A_PC:   op_a = pc_q;
            OP_A_ZERO: op_a = '0;
            default:   op_a = rs1_data_i;
        endcase
        case (op_b_sel_i)
            OP_B_IMM:  op_b = imm_i;
            OP_B_FOUR: op_b = `RV_XLEN'd4;
            default:   op_b = rs2_data_i;
        endcase
    end

    ////////////////////
    // alu
    ////////////////////
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;
    assign shamt = op_b[4:0]; // low five bits only, as per rv32i

    always_comb begin
        alu_res  = '0;
        alu_flag = 1'b0;
        case (alu_op_i)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            // compares, flag only
            ALU_EQ:   alu_flag = (op_a == op_b);
            ALU_NE:   alu_flag = (op_a != op_b);
            ALU_LT:   alu_flag = lt_s;
            ALU_GE:   alu_flag = !lt_s;
            ALU_LTU:  alu_flag = lt_u;
            default:  alu_flag = !lt_u; // geu
        endcase
    end

    ////////////////////
    // program counter
    ////////////////////
    assign take_target = jal_i || (branch_i && alu_flag);
    assign pc_next     = take_target ? (pc_q + imm_i) : (pc_q + `RV_XLEN'd4);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc_q <= `RV_RESET_PC;
        end else begin
            pc_q <= pc_next; // one instruction per edge
        end
    end

    assign pc_o       = pc_q;
    assign wb_data_o  = alu_res;    // jal link comes out as pc + 4
    assign mem_we_o   = store_i;    // already gated by decoder
    assign mem_addr_o = alu_res;    // rs1 + imm on stores
    assign mem_data_o = rs2_data_i;

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic [`RV_ILEN-1:0] instr_i,    // word fetched at pc_o
    output logic [`RV_XLEN-1:0] pc_o,
    output logic                mem_we_o,   // store port, valid all cycle
    output logic [`RV_XLEN-1:0] mem_addr_o,
    output logic [`RV_XLEN-1:0] mem_data_o,
    output logic                illegal_o
);

    // decoder to register file
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic                  rd_we;

    // decoder to execute
    alu_op_e               alu_op;
    op_a_sel_e             op_a_sel;
    op_b_sel_e             op_b_sel;
    logic [`RV_XLEN-1:0]   imm;
    logic                  branch;
    logic                  jal;
    logic                  store;

    // register file and execute loop
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic [`RV_XLEN-1:0]   wb_data;

    rv_decoder u_decoder (
        .instr_i    (instr_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .rd_we_o    (rd_we),
        .alu_op_o   (alu_op),
        .op_a_sel_o (op_a_sel),
        .op_b_sel_o (op_b_sel),
        .imm_o      (imm),
        .branch_o   (branch),
        .jal_o      (jal),
        .store_o    (store),
        .illegal_o  (illegal_o)
    );

    // reads in parallel with decode
    rv_regfile u_regfile (
        .CLK   (CLK),
        .RESET (RESET),
        .ra1_i (rs1_addr),
        .ra2_i (rs2_addr),
        .wa_i  (rd_addr),
        .wd_i  (wb_data),   // write-back from execute
        .we_i  (rd_we),
        .rd1_o (rs1_data),
        .rd2_o (rs2_data)
    );

    rv_execute u_execute (
        .CLK        (CLK),
        .RESET      (RESET),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .imm_i      (imm),
        .alu_op_i   (alu_op),
        .op_a_sel_i (op_a_sel),
        .op_b_sel_i (op_b_sel),
        .branch_i   (branch),
        .jal_i      (jal),
        .store_i    (store),
        .pc_o       (pc_o),
        .wb_data_o  (wb_data),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_data_o (mem_data_o)
    );

endmodule

`default_nettype wire

// ==== tests/rv_core_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module rv_core_assertions
    import rv_pkg::*;
(
    input logic                CLK,
    input logic                RESET,
    input logic [`RV_ILEN-1:0] instr_i,
    input logic [`RV_XLEN-1:0] pc_i,
    input logic                mem_we_i,
    input logic [`RV_XLEN-1:0] mem_data_i,
    input logic                illegal_i,
    input logic [`RV_XLEN-1:0] wb_data_i    // internal write-back
);

    // fetch restarts at the reset vector
    reset_pc_a: assert property (@(posedge CLK) $fell(RESET) |-> pc_i == `RV_RESET_PC)
        else $error("pc_o is not the reset vector in the first cycle after reset");

    pc_align_a: assert property (@(posedge CLK) disable iff (RESET) pc_i[1:0] == 2'b00)
        else $error("pc_o is not word aligned");

    // illegal words retire with no side effect
    illegal_store_a: assert property (@(posedge CLK) disable iff (RESET)
        illegal_i |-> !mem_we_i)
        else $error("store enabled on an illegal instruction");
    illegal_pc_a: assert property (@(posedge CLK) disable iff (RESET)
        illegal_i |=> pc_i == $past(pc_i) + 32'd4)
        else $error("pc did not advance by 4 after an illegal instruction");

    store_opc_a: assert property (@(posedge CLK) mem_we_i |-> instr_i[6:0] == OPC_STORE)
        else $error("mem_we_o high without a store opcode on instr_i");

    // x0 reads back as zero
    x0_zero_a: assert property (@(posedge CLK) disable iff (RESET)
        mem_we_i && instr_i[24:20] == 5'd0 |-> mem_data_i == '0)
        else $error("sw of x0 stored a nonzero value");

    jal_link_a: assert property (@(posedge CLK) disable iff (RESET)
        instr_i[6:0] == OPC_JAL |-> wb_data_i == pc_i + 32'd4)
        else $error("jal link value is not pc + 4");

endmodule

bind rv_core rv_core_assertions u_core_assertions (
    .CLK        (CLK),
    .RESET      (RESET),
    .instr_i    (instr_i),
    .pc_i       (pc_o),
    .mem_we_i   (mem_we_o),
    .mem_data_i (mem_data_o),
    .illegal_i  (illegal_o),
    .wb_data_i  (wb_data)
);

`default_nettype wire

// ==== tests/tb_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module tb_core;

    localparam int          PROG_LEN       = 64;
    localparam int          RESET_CYCLES   = 3;
    localparam int          TIMEOUT_CYCLES = 3 * PROG_LEN + RESET_CYCLES + 5; // 200
    localparam logic [31:0] END_PC         = PROG_LEN * 4;
    localparam logic [31:0] NOP            = 32'h0000_0013; // addi x0, x0, 0

    logic                CLK = 1'b0;
    logic                RESET;
    logic [`RV_ILEN-1:0] instr_i;
    logic [`RV_XLEN-1:0] pc_o;
    logic                mem_we_o;
    logic [`RV_XLEN-1:0] mem_addr_o;
    logic [`RV_XLEN-1:0] mem_data_o;
    logic                illegal_o;

    logic [31:0] prog [PROG_LEN];        // program image by word index
    logic [31:0] m_regs [`RV_NUM_REGS];  // reference register file
    logic [31:0] m_pc;                   // reference pc
    int          seed;
    int          cycles = 0;
    logic        done;

    rv_core i_rv_core (
        .CLK        (CLK),
        .RESET      (RESET),
        .instr_i    (instr_i),
        .pc_o       (pc_o),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_data_o (mem_data_o),
        .illegal_o  (illegal_o)
    );

    always #20 CLK = ~CLK; // 40 ns period

    ////////////////////
    // reference model
    ////////////////////

    // rv32i alu for op and op_imm with alt taken from instr[30]
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s mismatch", name);
    endtask

    // retire the word on instr_i in the model and check the store port
    task automatic step_model();
        logic [31:0] ins, a, b, imm_i, res, npc, addr;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        ill, wr, st, take;
        ins   = instr_i;
        f7    = ins[31:25];
        f3    = ins[14:12];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        ill   = 1'b0;
        wr    = 1'b0;
        st    = 1'b0;
        take  = 1'b0;
        res   = '0;
        addr  = '0;
        npc   = m_pc + 32'd4; // fall-through also for illegal words
        case (ins[6:0])
            7'b0110011: begin // op
                ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                wr  = 1'b1;
                res = alu_ref(f3, f7[5], a, b);
            end
            7'b0010011: begin // op_imm where funct7 matters for shifts only
                ill = (f3 == 3'd1 && f7 != 7'h00) ||
                      (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                wr  = 1'b1;
                res = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
            end
            7'b0110111: begin // lui
                wr  = 1'b1;
                res = {ins[31:12], 12'b0};
            end
            7'b1100011: begin // branch where funct3[0] inverts the compare
                ill  = (f3[2:1] == 2'b01);
                take = (f3[2:1] == 2'b00) ? (a == b) :
                       (f3[2:1] == 2'b10) ? ($signed(a) < $signed(b)) : (a < b);
                if (!ill && (take ^ f3[0])) begin
                    npc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin // jal
                wr  = 1'b1;
                res = m_pc + 32'd4;
                npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b0100011: begin // sw only
                ill  = (f3 != 3'd2);
                st   = !ill;
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            default: ill = 1'b1;
        endcase
        assert (illegal_o == ill)
            else report_mismatch("illegal flag", 32'(ill), 32'(illegal_o));
        assert (mem_we_o == st)
            else report_mismatch("store enable", 32'(st), 32'(mem_we_o));
        if (st) begin
            assert (mem_addr_o == addr) else report_mismatch("store address", addr, mem_addr_o);
            assert (mem_data_o == b) else report_mismatch("store data", b, mem_data_o);
        end
        if (wr && !ill && ins[11:7] != 5'd0) begin
            m_regs[ins[11:7]] = res; // x0 stays zero
        end
        m_pc = npc;
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    // control flow only goes forward so the end of the array is always reached
    task automatic build_program();
        logic [31:0] r, s;
        logic [2:0]  f3;
        logic [12:0] off;
        int          i;
        int          j;
        int          k;
        prog[0] = NOP;           // retired in the first cycle after reset
        prog[1] = 32'h0000_2223; // sw x0, 4(x0)
        i = 2;
        while (i < PROG_LEN) begin
            r  = $random(seed);
            s  = $random(seed);
            f3 = r[14:12];
            k  = 1 + s[5:4];                       // jump distance in words
            k  = (i + k > PROG_LEN) ? PROG_LEN - i : k; // land at most on the end
            off = 13'(k * 4);
            case (s[2:0])
                3'd0, 3'd1: begin // reg-reg alu
                    prog[i] = {((f3 == 3'd0 || f3 == 3'd5) && s[3]) ? 7'h20 : 7'h00,
                               r[24:7], 7'b0110011};
                end
                3'd2, 3'd3: begin // reg-imm alu
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        r[31:25] = (f3 == 3'd5 && s[3]) ? 7'h20 : 7'h00;
                    end
                    prog[i] = {r[31:7], 7'b0010011};
                end
                3'd4: prog[i] = {r[31:7], 7'b0110111}; // lui
                3'd5: begin // forward branch with 010 / 011 folded onto beq / bne
                    f3[1]   = f3[2] ? f3[1] : 1'b0;
                    prog[i] = {off[12], off[10:5], r[24:15], f3, off[4:1], off[11],
                               7'b1100011};
                end
                3'd6: begin // jal onto a sw of the link register
                    prog[i] = {1'b0, off[10:1], off[11], 8'b0, r[11:7], 7'b1101111};
                    // skipped words hold ecall
                    for (j = 1; j < k; j++) begin
                        prog[i + j] = 32'h0000_0073;
                    end
                    i = i + k - 1;
                end
                default: begin
                    case (s[7:5])
                        3'd0:    prog[i] = 32'h0000_0073;                          // ecall
                        3'd1:    prog[i] = {r[31:15], 3'b010, r[11:7], 7'b0000011}; // lw
                        3'd2:    prog[i] = {7'h01, r[24:7], 7'b0110011};            // mul
                        3'd3:    prog[i] = {r[31:15], 3'b000, r[11:7], 7'b0100011}; // sb
                        default: prog[i] = {r[31:15], 3'b010, r[11:7], 7'b0100011}; // sw
                    endcase
                end
            endcase
            i++;
            // sw of the destination right after a result or on the jal target
            if ((s[2:0] <= 3'd4 || s[2:0] == 3'd6) && i < PROG_LEN) begin
                prog[i] = {s[31:25], r[11:7], s[12:8], 3'b010, s[17:13], 7'b0100011};
                i++;
            end
        end
    endtask

    // model steps on the retiring edge
    always @(posedge CLK) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the end of the program was not reached within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end else if (RESET) begin
            m_pc = `RV_RESET_PC;
            for (int j = 0; j < `RV_NUM_REGS; j++) begin
                m_regs[j] = '0;
            end
        end else begin
            step_model();
        end
    end

    initial begin
        seed    = 21;
        done    = 1'b0;
        RESET   = 1'b1;
        instr_i = NOP; // held through reset
        build_program();
        repeat (RESET_CYCLES) @(negedge CLK);
        RESET = 1'b0;
        while (!done) begin
            @(negedge CLK);
            assert (pc_o == m_pc) else report_mismatch("pc", m_pc, pc_o);
            if (pc_o >= END_PC) begin
                done = 1'b1;
            end else begin
                instr_i = prog[pc_o[7:2]]; // fetch at pc_o
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_core.sv
tests/rv_core_assertions.sv
tests/tb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_core -o tb_core_sim \
    && ./obj_dir/tb_core_sim > sim.log 2>&1
grep -qF '*** TEST PASSED ***' sim.log && echo "PASS" || { cat sim.log 2>/dev/null; echo "FAIL"; exit 1; }
